/* rtl/sync_const_pkg.sv */
`default_nettype none

package sync_const_pkg;

    // Field identity as seen at the vsync leading edge
    localparam logic FID_EVEN = 1'b0;
    localparam logic FID_ODD  = 1'b1;

    // Vsync source type
    // Separated vsync is referenced to the last accepted hsync edge
    localparam logic VSYNC_SEPARATED = 1'b0;
    localparam logic VSYNC_RAW       = 1'b1;

    // Line counts and vtotal
    localparam int LINE_CNT_W = 11;

    // Line length in measurement clock cycles
    localparam int PCNT_LINE_W = 12;

    // Field length in measurement clock cycles
    localparam int PCNT_FIELD_W = 20;

    // Hsync pulse width in measurement clock cycles
    localparam int HS_WIDTH_W = 8;

endpackage

`default_nettype wire

/* rtl/meas_window_pkg.sv */
`default_nettype none

package meas_window_pkg;

    // One polarity and activity sampling window is 2^18 cycles
    localparam int POL_WINDOW_W = 18;

    // Sync goes inactive after 8 stale windows
    localparam int STALE_CTR_W = 3;

    // Frame cycle counter that saturates at all ones
    localparam int PCNT_FRAME_W = 21;

    // Line length is latched once this many cycles into the frame
    // which is well clear of the vertical sync and equalization pulses
    localparam logic [PCNT_FRAME_W-1:0] LINE_STORE_DELAY = PCNT_FRAME_W'(27000);

    // Polarity threshold at half of a full window
    localparam logic [POL_WINDOW_W-1:0] POL_HALF_WINDOW =
        {1'b0, {(POL_WINDOW_W-1){1'b1}}};

endpackage

`default_nettype wire

/* rtl/sync_polarity_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_polarity_detect
    import meas_window_pkg::*;
(
    input  logic CLK_MEAS_i,
    input  logic reset_i,
    input  logic hsync_i,
    input  logic vsync_i,
    output logic hsync_pol_o,
    output logic vsync_pol_o,
    output logic sync_active_o
);

    logic [POL_WINDOW_W-1:0] win_ctr;
    logic [POL_WINDOW_W-1:0] hs_high_ctr;
    logic [POL_WINDOW_W-1:0] vs_high_ctr;
    logic [STALE_CTR_W-1:0]  stale_ctr;
    logic                    vs_stale;

    // Vsync never toggled during the window
    assign vs_stale = (vs_high_ctr == '0) | (vs_high_ctr == '1);

    always_ff @(posedge CLK_MEAS_i) begin
        if (reset_i) begin
            // First window starts right after reset
            win_ctr       <= POL_WINDOW_W'(1);
            hs_high_ctr   <= '0;
            vs_high_ctr   <= '0;
            stale_ctr     <= '0;
            hsync_pol_o   <= 1'b0;
            vsync_pol_o   <= 1'b0;
            sync_active_o <= 1'b0;
        end else begin
            win_ctr <= win_ctr + 1'b1;

            if (win_ctr == '0) begin
                // Mostly high at window end means active low pulses
                hsync_pol_o <= (hs_high_ctr > POL_HALF_WINDOW);
                vsync_pol_o <= (vs_high_ctr > POL_HALF_WINDOW);
                hs_high_ctr <= '0;
                vs_high_ctr <= '0;

                if (vs_stale) begin
                    if (stale_ctr == '1)
                        sync_active_o <= 1'b0;
                    else
                        stale_ctr <= stale_ctr + 1'b1;
                end else begin
                    stale_ctr     <= '0;
                    sync_active_o <= 1'b1;
                end
            end else begin
                if (hsync_i)
                    hs_high_ctr <= hs_high_ctr + 1'b1;
                if (vsync_i)
                    vs_high_ctr <= vs_high_ctr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_edge_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_edge_decode (
    input  logic CLK_MEAS_i,
    input  logic reset_i,
    input  logic hsync_i,
    input  logic vsync_i,
    input  logic hsync_pol_i,
    input  logic vsync_pol_i,
    output logic hsync_np_o,
    output logic hs_fall_o,
    output logic vs_fall_o
);

    logic hs_np;
    logic vs_np;
    logic hs_np_q;
    logic vs_np_q;

    // Normalized sync is idle high with low pulses
    assign hs_np = hsync_i ^ ~hsync_pol_i;
    assign vs_np = vsync_i ^ ~vsync_pol_i;

    always_ff @(posedge CLK_MEAS_i) begin
        if (reset_i) begin
            hs_np_q   <= 1'b0;
            vs_np_q   <= 1'b0;
            hs_fall_o <= 1'b0;
            vs_fall_o <= 1'b0;
        end else begin
            hs_np_q   <= hs_np;
            vs_np_q   <= vs_np;
            hs_fall_o <= hs_np_q & ~hs_np;
            vs_fall_o <= vs_np_q & ~vs_np;
        end
    end

    // Level delayed to line up with the edge pulses
    assign hsync_np_o = hs_np_q;

endmodule

`default_nettype wire

/* rtl/pixel_count_meas.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_count_meas
    import sync_const_pkg::*, meas_window_pkg::*;
(
    input  logic                    CLK_MEAS_i,
    input  logic                    reset_i,
    input  logic                    hs_fall_i,
    input  logic                    vs_fall_i,
    input  logic                    hsync_np_i,
    input  logic                    sync_active_i,
    input  logic                    interlace_i,
    input  logic                    field_id_i,
    output logic [PCNT_LINE_W-1:0]  pcnt_line_o,
    output logic [HS_WIDTH_W-1:0]   hsync_width_o,
    output logic [PCNT_FIELD_W-1:0] pcnt_field_o,
    output logic                    vblank_region_o
);

    logic [PCNT_FRAME_W-1:0] frame_ctr;
    logic [PCNT_LINE_W-1:0]  line_ctr;
    logic [HS_WIDTH_W-1:0]   hs_low_ctr;
    logic                    line_stored;
    logic                    vs_qualify;

    logic [PCNT_FRAME_W-1:0] line_x4;
    logic [PCNT_FRAME_W-1:0] line_x8;
    logic [PCNT_FRAME_W-1:0] field_len;
    logic [PCNT_FRAME_W-1:0] frame_len;
    logic                    head_region;
    logic                    tail_region;
    logic                    mid_region;

    // Frame starts at progressive vsync or at the even field of interlaced video
    assign vs_qualify = vs_fall_i & (~interlace_i | (field_id_i == FID_EVEN));

    always_ff @(posedge CLK_MEAS_i) begin
        if (reset_i) begin
            frame_ctr    <= '0;
            pcnt_field_o <= '0;
        end else if (vs_qualify) begin
            frame_ctr <= PCNT_FRAME_W'(1);
            // Saturated counter means the frame was too long to be valid
            if (sync_active_i & (frame_ctr != '1)) begin
                if (interlace_i)
                    pcnt_field_o <= frame_ctr[PCNT_FRAME_W-1:1];
                else
                    pcnt_field_o <= frame_ctr[PCNT_FIELD_W-1:0];
            end
        end else if (frame_ctr != '1) begin
            frame_ctr <= frame_ctr + 1'b1;
        end else begin
            pcnt_field_o <= '0;
        end
    end

    always_ff @(posedge CLK_MEAS_i) begin
        if (reset_i) begin
            line_ctr      <= '0;
            hs_low_ctr    <= '0;
            line_stored   <= 1'b0;
            pcnt_line_o   <= '0;
            hsync_width_o <= '0;
        end else begin
            if (vs_qualify)
                line_stored <= 1'b0;

            if (hs_fall_i) begin
                line_ctr   <= PCNT_LINE_W'(1);
                hs_low_ctr <= HS_WIDTH_W'(1);
                // One sample per frame taken after the vsync area
                if (~line_stored & (frame_ctr > LINE_STORE_DELAY)) begin
                    pcnt_line_o   <= line_ctr;
                    hsync_width_o <= hs_low_ctr;
                    line_stored   <= 1'b1;
                end
            end else begin
                line_ctr <= line_ctr + 1'b1;
                if (~hsync_np_i)
                    hs_low_ctr <= hs_low_ctr + 1'b1;
            end
        end
    end

    // Region bounds in frame counter units
    assign line_x4   = PCNT_FRAME_W'({pcnt_line_o, 2'b00});
    assign line_x8   = PCNT_FRAME_W'({pcnt_line_o, 3'b000});
    assign field_len = PCNT_FRAME_W'(pcnt_field_o);
    assign frame_len = interlace_i ? (field_len << 1) : field_len;

    // First 8 lines and last 4 lines of the frame
    assign head_region = (frame_ctr < line_x8);
    assign tail_region = (frame_ctr > (frame_len - line_x4));

    // Blanking around the field boundary inside an interlaced frame
    assign mid_region = interlace_i &
                        (frame_ctr < (field_len + line_x8)) &
                        (frame_ctr > (field_len - line_x4));

    assign vblank_region_o = head_region | tail_region | mid_region;

endmodule

`default_nettype wire

/* rtl/line_field_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module line_field_tracker
    import sync_const_pkg::*;
(
    input  logic                   CLK_MEAS_i,
    input  logic                   reset_i,
    input  logic                   hs_fall_i,
    input  logic                   vs_fall_i,
    input  logic                   vsync_type_i,
    input  logic [PCNT_LINE_W-1:0] pcnt_line_i,
    input  logic                   vblank_region_i,
    output logic                   field_id_o,
    output logic                   interlace_o,
    output logic [LINE_CNT_W-1:0]  vtotal_o
);

    logic [PCNT_LINE_W-1:0] h_cnt;
    logic [PCNT_LINE_W-1:0] h_cnt_hsref;
    logic [LINE_CNT_W-1:0]  v_cnt;

    logic [PCNT_LINE_W-1:0] eighth_line;
    logic [PCNT_LINE_W-1:0] quarter_line;
    logic [PCNT_LINE_W-1:0] half_line;
    logic [PCNT_LINE_W-1:0] three_q_line;
    logic [PCNT_LINE_W-1:0] glitch_thold;
    logic [PCNT_LINE_W-1:0] h_cnt_ref;
    logic                   hs_accept;
    logic                   half_line_edge;
    logic                   line_overrun;
    logic                   odd_position;

    assign eighth_line  = pcnt_line_i >> 3;
    assign quarter_line = pcnt_line_i >> 2;
    assign half_line    = pcnt_line_i >> 1;
    assign three_q_line = half_line + quarter_line;

    // Blanking has serration pulses, so filter harder there
    assign glitch_thold = vblank_region_i ? quarter_line : eighth_line;

    assign hs_accept      = hs_fall_i & (h_cnt > glitch_thold);
    assign half_line_edge = (h_cnt > (half_line - quarter_line)) & (h_cnt < three_q_line);
    assign line_overrun   = vblank_region_i & (h_cnt >= pcnt_line_i);

    // Outer quarters of the line mean odd field
    assign h_cnt_ref    = (vsync_type_i == VSYNC_SEPARATED) ? h_cnt_hsref : h_cnt;
    assign odd_position = (h_cnt_ref < quarter_line) | (h_cnt_ref > three_q_line);

    always_ff @(posedge CLK_MEAS_i) begin
        if (reset_i) begin
            h_cnt       <= '0;
            h_cnt_hsref <= '0;
            v_cnt       <= '0;
            field_id_o  <= FID_EVEN;
            interlace_o <= 1'b0;
            vtotal_o    <= '0;
        end else begin
            if (hs_accept) begin
                // Equalization pulse keeps the current line running
                if (half_line_edge) begin
                    h_cnt <= h_cnt + 1'b1;
                end else begin
                    h_cnt <= '0;
                    v_cnt <= v_cnt + 1'b1;
                end
                h_cnt_hsref <= h_cnt;
            end else if (line_overrun) begin
                // Missing hsync in blanking
                h_cnt <= '0;
                v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end

            // Vsync overrides the line count update above
            if (vs_fall_i) begin
                if (odd_position) begin
                    field_id_o  <= FID_ODD;
                    interlace_o <= (field_id_o == FID_EVEN);

                    if (vsync_type_i == VSYNC_RAW) begin
                        // Raw vsync may land on the hsync edge or just either side
                        if (hs_fall_i | (h_cnt >= pcnt_line_i)) begin
                            v_cnt    <= LINE_CNT_W'(1);
                            vtotal_o <= v_cnt;
                        end else if (h_cnt < quarter_line) begin
                            v_cnt    <= LINE_CNT_W'(1);
                            vtotal_o <= v_cnt - 1'b1;
                        end else begin
                            v_cnt    <= '0;
                            vtotal_o <= v_cnt;
                        end
                    end else begin
                        v_cnt    <= '0;
                        vtotal_o <= v_cnt;
                    end
                end else begin
                    field_id_o  <= FID_EVEN;
                    interlace_o <= (field_id_o == FID_ODD);
                    if (field_id_o == FID_EVEN) begin
                        v_cnt    <= '0;
                        vtotal_o <= v_cnt;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_meas_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_meas_top
    import sync_const_pkg::*;
(
    input  wire                    CLK_MEAS_i,
    input  wire                    reset_i,
    input  wire                    hsync_i,
    input  wire                    vsync_i,
    input  wire                    vsync_type_i,
    output wire                    hsync_pol_o,
    output wire                    vsync_pol_o,
    output wire                    sync_active_o,
    output wire [PCNT_LINE_W-1:0]  pcnt_line_o,
    output wire [HS_WIDTH_W-1:0]   hsync_width_o,
    output wire [PCNT_FIELD_W-1:0] pcnt_field_o,
    output wire [LINE_CNT_W-1:0]   vtotal_o,
    output wire                    interlace_o
);

    wire hsync_np;
    wire hs_fall;
    wire vs_fall;
    wire vblank_region;
    wire field_id;

    sync_polarity_detect u_sync_polarity_detect (
        .CLK_MEAS_i    (CLK_MEAS_i),
        .reset_i       (reset_i),
        .hsync_i       (hsync_i),
        .vsync_i       (vsync_i),
        .hsync_pol_o   (hsync_pol_o),
        .vsync_pol_o   (vsync_pol_o),
        .sync_active_o (sync_active_o)
    );

    sync_edge_decode u_sync_edge_decode (
        .CLK_MEAS_i  (CLK_MEAS_i),
        .reset_i     (reset_i),
        .hsync_i     (hsync_i),
        .vsync_i     (vsync_i),
        .hsync_pol_i (hsync_pol_o),
        .vsync_pol_i (vsync_pol_o),
        .hsync_np_o  (hsync_np),
        .hs_fall_o   (hs_fall),
        .vs_fall_o   (vs_fall)
    );

    pixel_count_meas u_pixel_count_meas (
        .CLK_MEAS_i      (CLK_MEAS_i),
        .reset_i         (reset_i),
        .hs_fall_i       (hs_fall),
        .vs_fall_i       (vs_fall),
        .hsync_np_i      (hsync_np),
        .sync_active_i   (sync_active_o),
        .interlace_i     (interlace_o),
        .field_id_i      (field_id),
        .pcnt_line_o     (pcnt_line_o),
        .hsync_width_o   (hsync_width_o),
        .pcnt_field_o    (pcnt_field_o),
        .vblank_region_o (vblank_region)
    );

    line_field_tracker u_line_field_tracker (
        .CLK_MEAS_i      (CLK_MEAS_i),
        .reset_i         (reset_i),
        .hs_fall_i       (hs_fall),
        .vs_fall_i       (vs_fall),
        .vsync_type_i    (vsync_type_i),
        .pcnt_line_i     (pcnt_line_o),
        .vblank_region_i (vblank_region),
        .field_id_o      (field_id),
        .interlace_o     (interlace_o),
        .vtotal_o        (vtotal_o)
    );

endmodule

`default_nettype wire

/* sim/sync_meas_tests.svh */
`ifndef SYNC_MEAS_TESTS_SVH
`define SYNC_MEAS_TESTS_SVH

// Generator takes over these pattern settings at each frame start
int pat_len        = 100;
int pat_width      = 8;
bit pat_active_low = 1'b1;
bit pat_interlace  = 1'b0;
bit pat_hold       = 1'b0;
int frame_cnt      = 0;
int h_pos          = 0;

function automatic int random_line_len();
    return 90 + int'($urandom % 21);
endfunction

task automatic set_pattern(input int len, input int width, input bit low,
                           input bit interlace, input bit hold);
    pat_len        = len;
    pat_width      = width;
    pat_active_low = low;
    pat_interlace  = interlace;
    pat_hold       = hold;
endtask

// Vsync pulse sits at the start of the span and hsync follows the running line phase
task automatic drive_span(input int cycles, input int vs_cycles, input int len,
                          input int width, input bit low);
    int c;
    bit hs_act;
    bit vs_act;
    for (c = 0; c < cycles; c++) begin
        @(negedge CLK_MEAS_i);
        hs_act  = (h_pos < width);
        vs_act  = (c < vs_cycles);
        hsync_i = low ? ~hs_act : hs_act;
        vsync_i = low ? ~vs_act : vs_act;
        h_pos   = (h_pos == len - 1) ? 0 : h_pos + 1;
    end
endtask

task automatic run_pattern();
    int len;
    int width;
    bit low;
    forever begin
        len   = pat_len;
        width = pat_width;
        low   = pat_active_low;
        if (pat_hold) begin
            // Hsync keeps running while vsync stays idle
            drive_span(FIELD_LINES * len, 0, len, width, low);
        end else if (pat_interlace) begin
            // First field ends half way through a line
            drive_span(FIELD_LINES * len + len / 2, VS_LINES * len, len, width, low);
            drive_span(FIELD_LINES * len + len - len / 2, VS_LINES * len, len, width, low);
        end else begin
            drive_span(FIELD_LINES * len, VS_LINES * len, len, width, low);
        end
        frame_cnt++;
    end
endtask

task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target)
        @(negedge CLK_MEAS_i);
endtask

task automatic await_window_ends(input int n);
    longint target;
    target = ((cyc_cnt / WINDOW_CYC) + n) * WINDOW_CYC;
    while (cyc_cnt < target)
        @(negedge CLK_MEAS_i);
endtask

task automatic verify_reset_state();
    compare_value("sync_active_o after reset", sync_active_o, 0);
    compare_value("interlace_o after reset", interlace_o, 0);
    compare_value("hsync_pol_o after reset", hsync_pol_o, 0);
    compare_value("vsync_pol_o after reset", vsync_pol_o, 0);
    compare_value("pcnt_line_o after reset", pcnt_line_o, 0);
    compare_value("hsync_width_o after reset", hsync_width_o, 0);
    compare_value("pcnt_field_o after reset", pcnt_field_o, 0);
    compare_value("vtotal_o after reset", vtotal_o, 0);
endtask

task automatic detect_active_low();
    set_pattern(random_line_len(), 6 + int'($urandom % 8), 1'b1, 1'b0, 1'b0);
    fork
        run_pattern();
    join_none
    await_window_ends(1);
    compare_value("hsync_pol_o for active low hsync", hsync_pol_o, 1);
    compare_value("vsync_pol_o for active low vsync", vsync_pol_o, 1);
    compare_value("sync_active_o with running vsync", sync_active_o, 1);
endtask

task automatic measure_line_width();
    wait_frames(3);
    compare_value("pcnt_line_o", pcnt_line_o, pat_len);
    compare_value("hsync_width_o", hsync_width_o, pat_width);
endtask

task automatic track_progressive_frame();
    wait_frames(3);
    compare_value("pcnt_field_o progressive", pcnt_field_o, FIELD_LINES * pat_len);
    compare_value("vtotal_o progressive", vtotal_o, FIELD_LINES);
    compare_value("interlace_o progressive", interlace_o, 0);
endtask

task automatic track_interlaced_frame();
    set_pattern(random_line_len(), pat_width, 1'b1, 1'b1, 1'b0);
    wait_frames(6);
    compare_value("interlace_o interlaced", interlace_o, 1);
    // Two fields of FIELD_LINES and a half lines each
    compare_value("pcnt_field_o interlaced", pcnt_field_o,
                  ((2 * FIELD_LINES + 1) * pat_len) / 2);
endtask

task automatic detect_active_high();
    set_pattern(pat_len, pat_width, 1'b0, 1'b0, 1'b0);
    wait_frames(1);
    await_window_ends(2);
    compare_value("hsync_pol_o for active high hsync", hsync_pol_o, 0);
    compare_value("vsync_pol_o for active high vsync", vsync_pol_o, 0);
endtask

task automatic drop_sync_activity();
    set_pattern(pat_len, pat_width, 1'b0, 1'b0, 1'b1);
    wait_frames(1);
    await_window_ends(9);
    compare_value("sync_active_o with constant vsync", sync_active_o, 0);
endtask

`endif

/* sim/sync_meas_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_meas_tb
    import sync_const_pkg::*, meas_window_pkg::*;
();

    localparam int     WINDOW_CYC    = 1 << POL_WINDOW_W;
    localparam int     FIELD_LINES   = 320;
    localparam int     VS_LINES      = 3;
    // Longest frame is an interlaced pair of fields at the longest line
    localparam int     MAX_FRAME_CYC = (2 * FIELD_LINES + 1) * 110;
    localparam int     TEST_FRAMES   = 14;
    localparam int     TEST_WINDOWS  = 12;
    localparam longint WATCHDOG_NS   = 8 * (longint'(TEST_FRAMES) * MAX_FRAME_CYC
                                            + longint'(TEST_WINDOWS) * WINDOW_CYC + 16);

    logic                    CLK_MEAS_i;
    logic                    reset_i;
    logic                    hsync_i;
    logic                    vsync_i;
    logic                    vsync_type_i;
    wire                     hsync_pol_o;
    wire                     vsync_pol_o;
    wire                     sync_active_o;
    wire [PCNT_LINE_W-1:0]   pcnt_line_o;
    wire [HS_WIDTH_W-1:0]    hsync_width_o;
    wire [PCNT_FIELD_W-1:0]  pcnt_field_o;
    wire [LINE_CNT_W-1:0]    vtotal_o;
    wire                     interlace_o;
    longint                  cyc_cnt;
    int                      seed;

    sync_meas_top u_sync_meas_top (
        .CLK_MEAS_i    (CLK_MEAS_i),
        .reset_i       (reset_i),
        .hsync_i       (hsync_i),
        .vsync_i       (vsync_i),
        .vsync_type_i  (vsync_type_i),
        .hsync_pol_o   (hsync_pol_o),
        .vsync_pol_o   (vsync_pol_o),
        .sync_active_o (sync_active_o),
        .pcnt_line_o   (pcnt_line_o),
        .hsync_width_o (hsync_width_o),
        .pcnt_field_o  (pcnt_field_o),
        .vtotal_o      (vtotal_o),
        .interlace_o   (interlace_o)
    );

    always #4 CLK_MEAS_i = ~CLK_MEAS_i;

    // Windows end on multiples of WINDOW_CYC cycles since reset release
    always @(posedge CLK_MEAS_i) begin
        if (reset_i)
            cyc_cnt <= 0;
        else
            cyc_cnt <= cyc_cnt + 1;
    end

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    `include "sync_meas_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed         = 32'hc699;
        void'($urandom(seed));
        CLK_MEAS_i   = 1'b0;
        reset_i      = 1'b1;
        hsync_i      = 1'b1;
        vsync_i      = 1'b1;
        vsync_type_i = VSYNC_RAW;
        repeat (8) @(posedge CLK_MEAS_i);
        @(negedge CLK_MEAS_i);
        reset_i = 1'b0;

        verify_reset_state();
        detect_active_low();
        measure_line_width();
        track_progressive_frame();
        track_interlaced_frame();
        detect_active_high();
        drop_sync_activity();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
rtl/sync_const_pkg.sv
rtl/meas_window_pkg.sv
rtl/sync_polarity_detect.sv
rtl/sync_edge_decode.sv
rtl/pixel_count_meas.sv
rtl/line_field_tracker.sv
rtl/sync_meas_top.sv
sim/sync_meas_tb.sv
